/* all.f */
common/gpu_pkg.sv
source/fifo_queue.sv
source/dp_ram.sv
operands/gpr_bank.sv
operands/operand_collector.sv
source/rf_perf_counters.sv
source/operand_stage_top.sv
tb/operand_stage_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module operand_stage_tb \
		-Mdir obj_dir -o operand_stage_sim
	./obj_dir/operand_stage_sim | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/operand_stage_tb.sv */
`timescale 1ns/1ps

module operand_stage_tb;

    localparam int NT       = 4;
    localparam int XW       = gpu_pkg::XLEN;
    localparam int CW       = NT * XW;
    localparam int NUM_ROWS = 35;
    localparam int TIMEOUT  = 40 * NUM_ROWS + 200;

    localparam logic [2:0] K_WB    = 3'd0;
    localparam logic [2:0] K_ISSUE = 3'd1;
    localparam logic [2:0] K_READY = 3'd2;
    localparam logic [2:0] K_STALL = 3'd3;
    localparam logic [2:0] K_DRAIN = 3'd4;

    // flag is the opd_ready mode for K_READY (0 low, 1 high, 2 random)
    // and a latency check for K_ISSUE
    typedef struct packed {
        logic [2:0]  kind;
        logic [1:0]  wis;
        logic [4:0]  rd;
        logic [3:0]  mask;
        logic [31:0] base;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rs3;
        logic [1:0]  flag;
    } row_t;

    typedef struct packed {
        gpu_pkg::issue_meta_t   meta;
        logic [NT-1:0]          tmask;
        logic [NT-1:0][XW-1:0]  rs1;
        logic [NT-1:0][XW-1:0]  rs2;
        logic [NT-1:0][XW-1:0]  rs3;
    } exp_t;

    row_t rows [NUM_ROWS] = '{
        '{K_WB,    2'd0, 5'd1,  4'hf, 32'h1000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_WB,    2'd0, 5'd2,  4'hf, 32'h2000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_WB,    2'd0, 5'd3,  4'hf, 32'h3000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_WB,    2'd1, 5'd1,  4'hf, 32'h4100_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_WB,    2'd1, 5'd2,  4'hf, 32'h4200_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_WB,    2'd3, 5'd1,  4'hf, 32'h7100_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_WB,    2'd0, 5'd0,  4'hf, 32'hdead_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_READY, 2'd0, 5'd0,  4'h0, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 2'd1},
        '{K_DRAIN, 2'd0, 5'd0,  4'h0, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_ISSUE, 2'd0, 5'd4,  4'hf, 32'h0000_0100, 5'd1, 5'd2, 5'd3, 2'd1},
        '{K_ISSUE, 2'd1, 5'd5,  4'h3, 32'h0000_0200, 5'd1, 5'd2, 5'd0, 2'd0},
        '{K_ISSUE, 2'd3, 5'd6,  4'hc, 32'h0000_0300, 5'd1, 5'd0, 5'd0, 2'd0},
        '{K_ISSUE, 2'd0, 5'd7,  4'hf, 32'h0000_0400, 5'd0, 5'd1, 5'd0, 2'd0},
        '{K_WB,    2'd0, 5'd1,  4'h5, 32'h5000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_WB,    2'd1, 5'd2,  4'ha, 32'h6000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_ISSUE, 2'd0, 5'd8,  4'h9, 32'h0000_0500, 5'd1, 5'd1, 5'd2, 2'd0},
        '{K_ISSUE, 2'd1, 5'd9,  4'h6, 32'h0000_0600, 5'd2, 5'd1, 5'd2, 2'd0},
        '{K_DRAIN, 2'd0, 5'd0,  4'h0, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_ISSUE, 2'd3, 5'd10, 4'hf, 32'h0000_0700, 5'd1, 5'd1, 5'd1, 2'd1},
        '{K_DRAIN, 2'd0, 5'd0,  4'h0, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_READY, 2'd0, 5'd0,  4'h0, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_ISSUE, 2'd0, 5'd11, 4'hf, 32'h0000_0800, 5'd1, 5'd2, 5'd3, 2'd0},
        '{K_ISSUE, 2'd1, 5'd12, 4'hf, 32'h0000_0900, 5'd1, 5'd2, 5'd0, 2'd0},
        '{K_ISSUE, 2'd3, 5'd13, 4'hf, 32'h0000_0a00, 5'd1, 5'd0, 5'd0, 2'd0},
        '{K_STALL, 2'd0, 5'd0,  4'h0, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_READY, 2'd0, 5'd0,  4'h0, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 2'd2},
        '{K_ISSUE, 2'd0, 5'd14, 4'hf, 32'h0000_0b00, 5'd3, 5'd2, 5'd1, 2'd0},
        '{K_WB,    2'd3, 5'd1,  4'h6, 32'h7700_0000, 5'd0, 5'd0, 5'd0, 2'd0},
        '{K_ISSUE, 2'd3, 5'd15, 4'hf, 32'h0000_0c00, 5'd1, 5'd1, 5'd0, 2'd0},
        '{K_ISSUE, 2'd1, 5'd16, 4'h2, 32'h0000_0d00, 5'd1, 5'd2, 5'd0, 2'd0},
        '{K_ISSUE, 2'd0, 5'd17, 4'hf, 32'h0000_0e00, 5'd2, 5'd3, 5'd1, 2'd0},
        '{K_ISSUE, 2'd1, 5'd18, 4'hf, 32'h0000_0f00, 5'd2, 5'd2, 5'd2, 2'd0},
        '{K_ISSUE, 2'd0, 5'd19, 4'h4, 32'h0000_1000, 5'd1, 5'd1, 5'd1, 2'd0},
        '{K_READY, 2'd0, 5'd0,  4'h0, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 2'd1},
        '{K_DRAIN, 2'd0, 5'd0,  4'h0, 32'h0000_0000, 5'd0, 5'd0, 5'd0, 2'd0}
    };

    logic clk;
    logic reset;
    logic issue_valid;
    logic issue_ready;
    logic [gpu_pkg::UUID_BITS-1:0] issue_uuid;
    logic [gpu_pkg::WIS_BITS-1:0]  issue_wis;
    logic [NT-1:0]                 issue_tmask;
    logic [XW-1:0]                 issue_pc;
    logic                          issue_wb;
    logic [gpu_pkg::OP_BITS-1:0]   issue_op_type;
    logic                          issue_use_imm;
    logic [XW-1:0]                 issue_imm;
    logic [gpu_pkg::NR_BITS-1:0]   issue_rd;
    logic [gpu_pkg::NR_BITS-1:0]   issue_rs1;
    logic [gpu_pkg::NR_BITS-1:0]   issue_rs2;
    logic [gpu_pkg::NR_BITS-1:0]   issue_rs3;
    logic                          wb_valid;
    logic [gpu_pkg::WIS_BITS-1:0]  wb_wis;
    logic [gpu_pkg::NR_BITS-1:0]   wb_rd;
    logic [NT-1:0]                 wb_tmask;
    logic [NT-1:0][XW-1:0]         wb_data;
    logic                          opd_valid;
    logic                          opd_ready;
    logic [gpu_pkg::UUID_BITS-1:0] opd_uuid;
    logic [gpu_pkg::WIS_BITS-1:0]  opd_wis;
    logic [NT-1:0]                 opd_tmask;
    logic [XW-1:0]                 opd_pc;
    logic                          opd_wb;
    logic [gpu_pkg::OP_BITS-1:0]   opd_op_type;
    logic                          opd_use_imm;
    logic [XW-1:0]                 opd_imm;
    logic [gpu_pkg::NR_BITS-1:0]   opd_rd;
    logic [NT-1:0][XW-1:0]         opd_rs1_data;
    logic [NT-1:0][XW-1:0]         opd_rs2_data;
    logic [NT-1:0][XW-1:0]         opd_rs3_data;
    logic [gpu_pkg::PERF_CTR_BITS-1:0] perf_rf_reads;
    logic [gpu_pkg::PERF_CTR_BITS-1:0] perf_rf_writes;

    // reference register file, indexed by warp, register, lane
    logic [XW-1:0] ref_rf [4][gpu_pkg::NUM_REGS][NT];
    exp_t          exp_q [$];
    exp_t          head;
    int            ready_mode;
    int            cycle_count;
    logic [7:0]    uuid_next;
    logic          held;
    logic [gpu_pkg::UUID_BITS-1:0] held_uuid;
    logic [31:0]   exp_reads;
    logic [31:0]   exp_writes;

    operand_stage_top #(
        .NUM_THREADS (NT)
    ) operand_stage_top_i (
        .clk (clk), .reset (reset),
        .issue_valid (issue_valid), .issue_ready (issue_ready),
        .issue_uuid (issue_uuid), .issue_wis (issue_wis), .issue_tmask (issue_tmask),
        .issue_pc (issue_pc), .issue_wb (issue_wb), .issue_op_type (issue_op_type),
        .issue_use_imm (issue_use_imm), .issue_imm (issue_imm), .issue_rd (issue_rd),
        .issue_rs1 (issue_rs1), .issue_rs2 (issue_rs2), .issue_rs3 (issue_rs3),
        .wb_valid (wb_valid), .wb_wis (wb_wis), .wb_rd (wb_rd),
        .wb_tmask (wb_tmask), .wb_data (wb_data),
        .opd_valid (opd_valid), .opd_ready (opd_ready),
        .opd_uuid (opd_uuid), .opd_wis (opd_wis), .opd_tmask (opd_tmask),
        .opd_pc (opd_pc), .opd_wb (opd_wb), .opd_op_type (opd_op_type),
        .opd_use_imm (opd_use_imm), .opd_imm (opd_imm), .opd_rd (opd_rd),
        .opd_rs1_data (opd_rs1_data), .opd_rs2_data (opd_rs2_data),
        .opd_rs3_data (opd_rs3_data),
        .perf_rf_reads (perf_rf_reads), .perf_rf_writes (perf_rf_writes)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [CW-1:0] got,
                               input logic [CW-1:0] exp);
        assert (got === exp)
        else stop_on_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // distinct word per lane
    function automatic logic [XW-1:0] lane_word(input logic [31:0] base, input int t);
        return base + 32'(t) * 32'h0001_0011;
    endfunction

    function automatic logic [XW-1:0] ref_read(input logic [1:0] wis, input logic [4:0] r,
                                               input int t);
        return (r == 5'd0) ? '0 : ref_rf[wis][r][t];
    endfunction

    task automatic apply_wb(input row_t r);
        wb_valid = 1'b1;
        wb_wis   = r.wis;
        wb_rd    = r.rd;
        wb_tmask = r.mask;
        for (int t = 0; t < NT; t++) begin
            wb_data[t] = lane_word(r.base, t);
            if (r.mask[t]) begin
                ref_rf[r.wis][r.rd][t] = lane_word(r.base, t);
            end
        end
        @(posedge clk);
        #1;
        wb_valid = 1'b0;
    endtask

    task automatic apply_issue(input row_t r);
        exp_t e;
        e.meta.uuid    = uuid_next;
        e.meta.wis     = r.wis;
        e.meta.pc      = r.base;
        e.meta.wb      = uuid_next[1];
        e.meta.op_type = uuid_next[3:0];
        e.meta.use_imm = uuid_next[0];
        e.meta.imm     = ~r.base;
        e.meta.rd      = r.rd;
        e.tmask        = r.mask;
        for (int t = 0; t < NT; t++) begin
            e.rs1[t] = ref_read(r.wis, r.rs1, t);
            e.rs2[t] = ref_read(r.wis, r.rs2, t);
            e.rs3[t] = ref_read(r.wis, r.rs3, t);
        end
        issue_uuid    = e.meta.uuid;
        issue_wis     = e.meta.wis;
        issue_tmask   = e.tmask;
        issue_pc      = e.meta.pc;
        issue_wb      = e.meta.wb;
        issue_op_type = e.meta.op_type;
        issue_use_imm = e.meta.use_imm;
        issue_imm     = e.meta.imm;
        issue_rd      = e.meta.rd;
        issue_rs1     = r.rs1;
        issue_rs2     = r.rs2;
        issue_rs3     = r.rs3;
        issue_valid   = 1'b1;
        // issue_ready only moves on clock edges
        while (!issue_ready) begin
            @(posedge clk);
            #1;
        end
        exp_q.push_back(e);
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        uuid_next   = uuid_next + 8'd1;
        if (r.flag[0]) begin
            check_value("opd_valid", CW'(opd_valid), CW'(0));
            @(posedge clk);
            #1;
            check_value("opd_valid", CW'(opd_valid), CW'(1));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            stop_on_error("timeout: the stage stopped making progress");
        end
    end

    // opd_ready lags the row loop by one extra ns
    initial begin
        void'($urandom(32'hb226));
        forever begin
            @(posedge clk);
            #2;
            if (ready_mode == 0) begin
                opd_ready = 1'b0;
            end else if (ready_mode == 1) begin
                opd_ready = 1'b1;
            end else begin
                opd_ready = 1'($urandom % 2);
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (held) begin
                check_value("opd_valid", CW'(opd_valid), CW'(1));
                check_value("opd_uuid", CW'(opd_uuid), CW'(held_uuid));
            end
            if (opd_valid && opd_ready) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("an instruction left the stage that was never issued");
                end else begin
                    head = exp_q.pop_front();
                    check_value("opd_uuid", CW'(opd_uuid), CW'(head.meta.uuid));
                    check_value("opd_wis", CW'(opd_wis), CW'(head.meta.wis));
                    check_value("opd_tmask", CW'(opd_tmask), CW'(head.tmask));
                    check_value("opd_pc", CW'(opd_pc), CW'(head.meta.pc));
                    check_value("opd_wb", CW'(opd_wb), CW'(head.meta.wb));
                    check_value("opd_op_type", CW'(opd_op_type), CW'(head.meta.op_type));
                    check_value("opd_use_imm", CW'(opd_use_imm), CW'(head.meta.use_imm));
                    check_value("opd_imm", CW'(opd_imm), CW'(head.meta.imm));
                    check_value("opd_rd", CW'(opd_rd), CW'(head.meta.rd));
                    check_value("opd_rs1_data", opd_rs1_data, head.rs1);
                    check_value("opd_rs2_data", opd_rs2_data, head.rs2);
                    check_value("opd_rs3_data", opd_rs3_data, head.rs3);
                end
            end
            held      = opd_valid && !opd_ready;
            held_uuid = opd_uuid;
        end
    end

    initial begin
        cycle_count   = 0;
        ready_mode    = 1;
        uuid_next     = 8'd0;
        held          = 1'b0;
        held_uuid     = '0;
        reset         = 1'b1;
        issue_valid   = 1'b0;
        issue_uuid    = '0;
        issue_wis     = '0;
        issue_tmask   = '0;
        issue_pc      = '0;
        issue_wb      = 1'b0;
        issue_op_type = '0;
        issue_use_imm = 1'b0;
        issue_imm     = '0;
        issue_rd      = '0;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_rs3     = '0;
        wb_valid      = 1'b0;
        wb_wis        = '0;
        wb_rd         = '0;
        wb_tmask      = '0;
        wb_data       = '0;
        opd_ready     = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        check_value("opd_valid", CW'(opd_valid), CW'(0));
        check_value("issue_ready", CW'(issue_ready), CW'(1));
        check_value("perf_rf_reads", CW'(perf_rf_reads), CW'(0));
        check_value("perf_rf_writes", CW'(perf_rf_writes), CW'(0));

        for (int i = 0; i < NUM_ROWS; i++) begin
            case (rows[i].kind)
                K_WB:    apply_wb(rows[i]);
                K_ISSUE: apply_issue(rows[i]);
                K_READY: begin
                    ready_mode = int'(rows[i].flag);
                    @(posedge clk);
                    #1;
                end
                K_STALL: begin
                    // two entries queued and execute stalled
                    check_value("issue_ready", CW'(issue_ready), CW'(0));
                    repeat (2) @(posedge clk);
                    #1;
                    check_value("issue_ready", CW'(issue_ready), CW'(0));
                    check_value("opd_valid", CW'(opd_valid), CW'(1));
                end
                default: begin
                    while (exp_q.size() != 0) begin
                        @(posedge clk);
                        #1;
                    end
                end
            endcase
        end

        @(posedge clk);
        #1;
        exp_reads  = '0;
        exp_writes = '0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].kind == K_ISSUE) begin
                exp_reads = exp_reads + 32'(3 * NT);
            end else if (rows[i].kind == K_WB) begin
                exp_writes = exp_writes + 32'(3 * $countones(rows[i].mask));
            end
        end
        check_value("perf_rf_reads", CW'(perf_rf_reads), CW'(exp_reads));
        check_value("perf_rf_writes", CW'(perf_rf_writes), CW'(exp_writes));

        $display(">>> PASS");
        $finish;
    end

endmodule

/* source/operand_stage_top.sv */
`timescale 1ns/1ps

module operand_stage_top #(
    parameter int NUM_THREADS = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,

    input  logic                                      issue_valid,
    output logic                                      issue_ready,
    input  logic [gpu_pkg::UUID_BITS-1:0]             issue_uuid,
    input  logic [gpu_pkg::WIS_BITS-1:0]              issue_wis,
    input  logic [NUM_THREADS-1:0]                    issue_tmask,
    input  logic [gpu_pkg::XLEN-1:0]                  issue_pc,
    input  logic                                      issue_wb,
    input  logic [gpu_pkg::OP_BITS-1:0]               issue_op_type,
    input  logic                                      issue_use_imm,
    input  logic [gpu_pkg::XLEN-1:0]                  issue_imm,
    input  logic [gpu_pkg::NR_BITS-1:0]               issue_rd,
    input  logic [gpu_pkg::NR_BITS-1:0]               issue_rs1,
    input  logic [gpu_pkg::NR_BITS-1:0]               issue_rs2,
    input  logic [gpu_pkg::NR_BITS-1:0]               issue_rs3,

    input  logic                                      wb_valid,
    input  logic [gpu_pkg::WIS_BITS-1:0]              wb_wis,
    input  logic [gpu_pkg::NR_BITS-1:0]               wb_rd,
    input  logic [NUM_THREADS-1:0]                    wb_tmask,
    input  logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] wb_data,

    output logic                                      opd_valid,
    input  logic                                      opd_ready,
    output logic [gpu_pkg::UUID_BITS-1:0]             opd_uuid,
    output logic [gpu_pkg::WIS_BITS-1:0]              opd_wis,
    output logic [NUM_THREADS-1:0]                    opd_tmask,
    output logic [gpu_pkg::XLEN-1:0]                  opd_pc,
    output logic                                      opd_wb,
    output logic [gpu_pkg::OP_BITS-1:0]               opd_op_type,
    output logic                                      opd_use_imm,
    output logic [gpu_pkg::XLEN-1:0]                  opd_imm,
    output logic [gpu_pkg::NR_BITS-1:0]               opd_rd,
    output logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] opd_rs1_data,
    output logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] opd_rs2_data,
    output logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] opd_rs3_data,

    output logic [gpu_pkg::PERF_CTR_BITS-1:0]         perf_rf_reads,
    output logic [gpu_pkg::PERF_CTR_BITS-1:0]         perf_rf_writes
);
    logic                             issue_fire;
    logic [$clog2(NUM_THREADS+1)-1:0] wb_fire;

    operand_collector #(
        .NUM_THREADS (NUM_THREADS)
    ) collector (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue_uuid    (issue_uuid),
        .issue_wis     (issue_wis),
        .issue_tmask   (issue_tmask),
        .issue_pc      (issue_pc),
        .issue_wb      (issue_wb),
        .issue_op_type (issue_op_type),
        .issue_use_imm (issue_use_imm),
        .issue_imm     (issue_imm),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_rs3     (issue_rs3),
        .wb_valid      (wb_valid),
        .wb_wis        (wb_wis),
        .wb_rd         (wb_rd),
        .wb_tmask      (wb_tmask),
        .wb_data       (wb_data),
        .opd_valid     (opd_valid),
        .opd_ready     (opd_ready),
        .opd_uuid      (opd_uuid),
        .opd_wis       (opd_wis),
        .opd_tmask     (opd_tmask),
        .opd_pc        (opd_pc),
        .opd_wb        (opd_wb),
        .opd_op_type   (opd_op_type),
        .opd_use_imm   (opd_use_imm),
        .opd_imm       (opd_imm),
        .opd_rd        (opd_rd),
        .opd_rs1_data  (opd_rs1_data),
        .opd_rs2_data  (opd_rs2_data),
        .opd_rs3_data  (opd_rs3_data),
        .issue_fire    (issue_fire),
        .wb_fire       (wb_fire)
    );

    rf_perf_counters #(
        .NUM_THREADS (NUM_THREADS)
    ) perf_counters (
        .clk            (clk),
        .reset          (reset),
        .issue_fire     (issue_fire),
        .wb_count       (wb_fire),
        .perf_rf_reads  (perf_rf_reads),
        .perf_rf_writes (perf_rf_writes)
    );

endmodule

/* source/rf_perf_counters.sv */
`timescale 1ns/1ps

module rf_perf_counters #(
    parameter int NUM_THREADS = 4
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              issue_fire,
    input  logic [$clog2(NUM_THREADS+1)-1:0]  wb_count,
    output logic [gpu_pkg::PERF_CTR_BITS-1:0] perf_rf_reads,
    output logic [gpu_pkg::PERF_CTR_BITS-1:0] perf_rf_writes
);
    localparam int CTRW = gpu_pkg::PERF_CTR_BITS;

    logic [CTRW-1:0] reads_inc;
    logic [CTRW-1:0] writes_inc;

    // all lanes of all three ports are read on every issue
    assign reads_inc = issue_fire ? CTRW'(3 * NUM_THREADS) : '0;

    // each enabled lane lands in three bank copies
    assign writes_inc = CTRW'(wb_count) * CTRW'(3);

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_rf_reads  <= '0;
            perf_rf_writes <= '0;
        end else begin
            perf_rf_reads  <= perf_rf_reads + reads_inc;
            perf_rf_writes <= perf_rf_writes + writes_inc;
        end
    end

endmodule

/* operands/operand_collector.sv */
`timescale 1ns/1ps

module operand_collector #(
    parameter int NUM_THREADS = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,

    input  logic                                      issue_valid,
    output logic                                      issue_ready,
    input  logic [gpu_pkg::UUID_BITS-1:0]             issue_uuid,
    input  logic [gpu_pkg::WIS_BITS-1:0]              issue_wis,
    input  logic [NUM_THREADS-1:0]                    issue_tmask,
    input  logic [gpu_pkg::XLEN-1:0]                  issue_pc,
    input  logic                                      issue_wb,
    input  logic [gpu_pkg::OP_BITS-1:0]               issue_op_type,
    input  logic                                      issue_use_imm,
    input  logic [gpu_pkg::XLEN-1:0]                  issue_imm,
    input  logic [gpu_pkg::NR_BITS-1:0]               issue_rd,
    input  logic [gpu_pkg::NR_BITS-1:0]               issue_rs1,
    input  logic [gpu_pkg::NR_BITS-1:0]               issue_rs2,
    input  logic [gpu_pkg::NR_BITS-1:0]               issue_rs3,

    input  logic                                      wb_valid,
    input  logic [gpu_pkg::WIS_BITS-1:0]              wb_wis,
    input  logic [gpu_pkg::NR_BITS-1:0]               wb_rd,
    input  logic [NUM_THREADS-1:0]                    wb_tmask,
    input  logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] wb_data,

    output logic                                      opd_valid,
    input  logic                                      opd_ready,
    output logic [gpu_pkg::UUID_BITS-1:0]             opd_uuid,
    output logic [gpu_pkg::WIS_BITS-1:0]              opd_wis,
    output logic [NUM_THREADS-1:0]                    opd_tmask,
    output logic [gpu_pkg::XLEN-1:0]                  opd_pc,
    output logic                                      opd_wb,
    output logic [gpu_pkg::OP_BITS-1:0]               opd_op_type,
    output logic                                      opd_use_imm,
    output logic [gpu_pkg::XLEN-1:0]                  opd_imm,
    output logic [gpu_pkg::NR_BITS-1:0]               opd_rd,
    output logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] opd_rs1_data,
    output logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] opd_rs2_data,
    output logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] opd_rs3_data,

    output logic                                      issue_fire,
    output logic [$clog2(NUM_THREADS+1)-1:0]          wb_fire
);
    localparam int QUEUE_DEPTH = 4;

    typedef struct packed {
        logic [NUM_THREADS-1:0]                    tmask;
        logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] rs1;
        logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] rs2;
        logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] rs3;
    } opd_data_t;

    gpu_pkg::issue_meta_t                      meta_q;
    gpu_pkg::issue_meta_t                      meta_head;
    logic [NUM_THREADS-1:0]                    tmask_q;
    logic                                      push_q;
    opd_data_t                                 data_in;
    opd_data_t                                 data_head;
    logic                                      meta_empty;
    logic                                      data_empty;
    logic                                      pop;
    logic [$clog2(QUEUE_DEPTH+1)-1:0]          meta_size;
    logic [gpu_pkg::RF_ADDR_BITS-1:0]          rs_addr [3];
    logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] rs_data [3];
    logic [gpu_pkg::RF_ADDR_BITS-1:0]          wr_addr;

    assign issue_fire = issue_valid && issue_ready;

    // one push can still be in flight, so stop accepting at two
    assign issue_ready = (meta_size < 2);

    assign rs_addr[0] = {issue_wis, issue_rs1};
    assign rs_addr[1] = {issue_wis, issue_rs2};
    assign rs_addr[2] = {issue_wis, issue_rs3};
    assign wr_addr    = {wb_wis, wb_rd};

    // lanes written this cycle
    always_comb begin
        wb_fire = '0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            wb_fire = wb_fire + (wb_valid && wb_tmask[t]);
        end
    end

    // one bank copy per source port, all fed by the same writeback
    for (genvar p = 0; p < 3; p++) begin : g_bank
        gpr_bank #(
            .NUM_THREADS (NUM_THREADS)
        ) bank (
            .clk   (clk),
            .reset (reset),
            .read  (issue_fire),
            .raddr (rs_addr[p]),
            .write (wb_valid),
            .waddr (wr_addr),
            .wmask (wb_tmask),
            .wdata (wb_data),
            .rdata (rs_data[p])
        );
    end

    // metadata waits one cycle to line up with the bank outputs
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            meta_q.uuid    <= issue_uuid;
            meta_q.wis     <= issue_wis;
            meta_q.pc      <= issue_pc;
            meta_q.wb      <= issue_wb;
            meta_q.op_type <= issue_op_type;
            meta_q.use_imm <= issue_use_imm;
            meta_q.imm     <= issue_imm;
            meta_q.rd      <= issue_rd;
            tmask_q        <= issue_tmask;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            push_q <= 1'b0;
        end else begin
            push_q <= issue_fire;
        end
    end

    assign data_in.tmask = tmask_q;
    assign data_in.rs1   = rs_data[0];
    assign data_in.rs2   = rs_data[1];
    assign data_in.rs3   = rs_data[2];

    // both queues move in lockstep
    assign opd_valid = !meta_empty && !data_empty;
    assign pop       = opd_valid && opd_ready;

    fifo_queue #(
        .DATA_T (gpu_pkg::issue_meta_t),
        .DEPTH  (QUEUE_DEPTH)
    ) meta_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (push_q),
        .pop      (pop),
        .data_in  (meta_q),
        .data_out (meta_head),
        .empty    (meta_empty),
        .full     (),
        .size     (meta_size)
    );

    fifo_queue #(
        .DATA_T (opd_data_t),
        .DEPTH  (QUEUE_DEPTH)
    ) data_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (push_q),
        .pop      (pop),
        .data_in  (data_in),
        .data_out (data_head),
        .empty    (data_empty),
        .full     (),
        .size     ()
    );

    assign opd_uuid     = meta_head.uuid;
    assign opd_wis      = meta_head.wis;
    assign opd_pc       = meta_head.pc;
    assign opd_wb       = meta_head.wb;
    assign opd_op_type  = meta_head.op_type;
    assign opd_use_imm  = meta_head.use_imm;
    assign opd_imm      = meta_head.imm;
    assign opd_rd       = meta_head.rd;
    assign opd_tmask    = data_head.tmask;
    assign opd_rs1_data = data_head.rs1;
    assign opd_rs2_data = data_head.rs2;
    assign opd_rs3_data = data_head.rs3;

endmodule

/* operands/gpr_bank.sv */
`timescale 1ns/1ps

module gpr_bank #(
    parameter int NUM_THREADS = 4
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        read,
    input  logic [gpu_pkg::RF_ADDR_BITS-1:0]            raddr,
    input  logic                                        write,
    input  logic [gpu_pkg::RF_ADDR_BITS-1:0]            waddr,
    input  logic [NUM_THREADS-1:0]                      wmask,
    input  logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0]   wdata,
    output logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0]   rdata
);
    localparam int SIZE = gpu_pkg::NUM_REGS << gpu_pkg::WIS_BITS;

    logic [gpu_pkg::RF_ADDR_BITS-1:0]          raddr_q;
    logic [NUM_THREADS-1:0][gpu_pkg::XLEN-1:0] ram_rdata;
    logic                                      is_zero_reg;

    // follows the ram output, which only moves on read
    always_ff @(posedge clk) begin
        if (reset) begin
            raddr_q <= '0;
        end else if (read) begin
            raddr_q <= raddr;
        end
    end

    // x0 in every warp
    assign is_zero_reg = (raddr_q[gpu_pkg::NR_BITS-1:0] == '0);

    for (genvar t = 0; t < NUM_THREADS; t++) begin : g_lane
        dp_ram #(
            .DATAW (gpu_pkg::XLEN),
            .SIZE  (SIZE)
        ) lane_ram (
            .clk   (clk),
            .read  (read),
            .write (write && wmask[t]),
            .waddr (waddr),
            .wdata (wdata[t]),
            .raddr (raddr),
            .rdata (ram_rdata[t])
        );

        assign rdata[t] = is_zero_reg ? '0 : ram_rdata[t];
    end

endmodule

/* source/dp_ram.sv */
`timescale 1ns/1ps

module dp_ram #(
    parameter int DATAW = 32,
    parameter int SIZE  = 128
) (
    input  logic                    clk,
    input  logic                    read,
    input  logic                    write,
    input  logic [$clog2(SIZE)-1:0] waddr,
    input  logic [DATAW-1:0]        wdata,
    input  logic [$clog2(SIZE)-1:0] raddr,
    output logic [DATAW-1:0]        rdata
);
    logic [DATAW-1:0] mem [SIZE];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // same-address read in a write cycle returns the old word
    always_ff @(posedge clk) begin
        if (read) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* source/fifo_queue.sv */
`timescale 1ns/1ps

module fifo_queue #(
    parameter type DATA_T = logic,
    parameter int  DEPTH  = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  logic                       pop,
    input  DATA_T                      data_in,
    output DATA_T                      data_out,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] size
);
    localparam int PTRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW = $clog2(DEPTH + 1);

    DATA_T           entries [DEPTH];
    logic [PTRW-1:0] rd_ptr;
    logic [PTRW-1:0] wr_ptr;
    logic [CNTW-1:0] count;
    logic            do_push;
    logic            do_pop;

    function automatic logic [PTRW-1:0] next_ptr(input logic [PTRW-1:0] ptr);
        return (ptr == PTRW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // a full queue still accepts a push when the head leaves in the same cycle
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    // head entry shows without a register stage
    assign data_out = entries[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNTW'(DEPTH));
    assign size     = count;

endmodule

/* common/gpu_pkg.sv */
package gpu_pkg;

    // data word and register file geometry
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int NR_BITS  = 5;

    // four warps share one issue slot
    localparam int WIS_BITS = 2;

    // bank address is {wis, reg}
    localparam int RF_ADDR_BITS = NR_BITS + WIS_BITS;

    localparam int UUID_BITS = 8;
    localparam int OP_BITS   = 4;

    localparam int PERF_CTR_BITS = 32;

    // control fields carried alongside the operands
    typedef struct packed {
        logic [UUID_BITS-1:0] uuid;
        logic [WIS_BITS-1:0]  wis;
        logic [XLEN-1:0]      pc;
        logic                 wb;
        logic [OP_BITS-1:0]   op_type;
        logic                 use_imm;
        logic [XLEN-1:0]      imm;
        logic [NR_BITS-1:0]   rd;
    } issue_meta_t;

endpackage
